//--- dmem_assertions.sv
`default_nettype none

`include "dmem_config.svh"

module dmem_assertions (
    input  wire                                          clk_i,
    input  wire                                          arst_n_i,
    input  wire  [`DMEM_NCORES-1:0]                      stall_i,
    input  wire  dmem_req_pkg::data_t [`DMEM_NCORES-1:0] rdata_i
);

    logic [`DMEM_NCORES-1:0] stall_prev;
    logic [`DMEM_NCORES-1:0] stall_fall; // completion this cycle

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stall_prev <= '0;
        end else begin
            stall_prev <= stall_i;
        end
    end

    assign stall_fall = stall_prev & ~stall_i;

    a_one_completion: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) $onehot0(stall_fall)
    ) else $error("more than one core completed in one cycle");

    a_stall_in_reset: assert property (
        @(posedge clk_i) !arst_n_i |-> stall_i == '0
    ) else $error("stall_o set while reset is active");

    for (genvar k = 0; k < `DMEM_NCORES; k++) begin : g_idle_rdata
        a_rdata_idle: assert property (
            @(posedge clk_i) disable iff (!arst_n_i) !stall_fall[k] |-> rdata_i[k] == '0
        ) else $error("core %0d got nonzero rdata_o outside its completion cycle", k);
    end

endmodule

bind dmem_controller dmem_assertions u_assertions (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .stall_i  (stall_o),
    .rdata_i  (rdata_o)
);

`default_nettype wire

//--- dmem_config.svh
`ifndef DMEM_CONFIG_SVH
`define DMEM_CONFIG_SVH

// cores sharing the data memory
`define DMEM_NCORES 4

// word address width, memory holds 2**DMEM_ADDRW words
`define DMEM_ADDRW 6

`define DMEM_DATAW 32 // strobe width is DMEM_DATAW/8

`endif

//--- dmem_controller.f
+incdir+.
dmem_req_pkg.sv
dmem_ctrl_pkg.sv
dmem_req_slots.sv
dmem_rr_arbiter.sv
dmem_reservation_table.sv
dmem_port_fsm.sv
dmem_sram.sv
dmem_controller.sv
tb_clock_gen.sv
dmem_assertions.sv
tb_dmem_controller.sv

//--- dmem_controller.sv
`default_nettype none

`include "dmem_config.svh"

module dmem_controller (
    input  wire                                          clk_i,
    input  wire                                          arst_n_i,
    input  wire  [`DMEM_NCORES-1:0]                      re_i,
    input  wire  [`DMEM_NCORES-1:0]                      we_i,
    input  wire  dmem_req_pkg::addr_t [`DMEM_NCORES-1:0] addr_i,
    input  wire  dmem_req_pkg::data_t [`DMEM_NCORES-1:0] wdata_i,
    input  wire  dmem_req_pkg::strb_t [`DMEM_NCORES-1:0] wstrb_i,
    input  wire  [`DMEM_NCORES-1:0]                      is_lr_i,
    input  wire  [`DMEM_NCORES-1:0]                      is_sc_i,
    output dmem_req_pkg::data_t [`DMEM_NCORES-1:0]       rdata_o,
    output logic [`DMEM_NCORES-1:0]                      stall_o
);

    // slot contents
    logic [`DMEM_NCORES-1:0]                pending;
    dmem_req_pkg::op_e   [`DMEM_NCORES-1:0] slot_op;
    dmem_req_pkg::addr_t [`DMEM_NCORES-1:0] slot_addr;
    dmem_req_pkg::data_t [`DMEM_NCORES-1:0] slot_wdata;
    dmem_req_pkg::strb_t [`DMEM_NCORES-1:0] slot_wstrb;
    logic [`DMEM_NCORES-1:0]                serve;

    logic                   grant_valid;
    dmem_req_pkg::core_t    grant_core;
    logic                   take;

    logic                   rsv_check;
    dmem_req_pkg::core_t    rsv_core;
    dmem_req_pkg::op_e      rsv_op;
    dmem_req_pkg::addr_t    rsv_addr;
    logic                   rsv_clear;
    logic                   sc_ok;

    // shared memory port
    logic                   mem_re;
    logic                   mem_we;
    dmem_req_pkg::addr_t    mem_addr;
    dmem_req_pkg::data_t    mem_wdata;
    dmem_req_pkg::strb_t    mem_wstrb;
    dmem_req_pkg::data_t    mem_rdata;

    dmem_req_slots u_slots (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .re_i      (re_i),
        .we_i      (we_i),
        .addr_i    (addr_i),
        .wdata_i   (wdata_i),
        .wstrb_i   (wstrb_i),
        .is_lr_i   (is_lr_i),
        .is_sc_i   (is_sc_i),
        .serve_i   (serve),
        .pending_o (pending),
        .op_o      (slot_op),
        .addr_o    (slot_addr),
        .wdata_o   (slot_wdata),
        .wstrb_o   (slot_wstrb),
        .stall_o   (stall_o)
    );

    dmem_rr_arbiter u_arbiter (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .pending_i     (pending),
        .take_i        (take),
        .grant_valid_o (grant_valid),
        .grant_core_o  (grant_core)
    );

    dmem_reservation_table u_rsv (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .check_i  (rsv_check),
        .core_i   (rsv_core),
        .op_i     (rsv_op),
        .addr_i   (rsv_addr),
        .clear_i  (rsv_clear),
        .sc_ok_o  (sc_ok)
    );

    dmem_port_fsm u_fsm (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .grant_valid_i (grant_valid),
        .grant_core_i  (grant_core),
        .op_i          (slot_op),
        .addr_i        (slot_addr),
        .wdata_i       (slot_wdata),
        .wstrb_i       (slot_wstrb),
        .sc_ok_i       (sc_ok),
        .mem_rdata_i   (mem_rdata),
        .take_o        (take),
        .serve_o       (serve),
        .rsv_check_o   (rsv_check),
        .rsv_core_o    (rsv_core),
        .rsv_op_o      (rsv_op),
        .rsv_addr_o    (rsv_addr),
        .rsv_clear_o   (rsv_clear),
        .mem_re_o      (mem_re),
        .mem_we_o      (mem_we),
        .mem_addr_o    (mem_addr),
        .mem_wdata_o   (mem_wdata),
        .mem_wstrb_o   (mem_wstrb),
        .rdata_o       (rdata_o)
    );

    dmem_sram u_sram (
        .clk_i   (clk_i),
        .re_i    (mem_re),
        .we_i    (mem_we),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .wstrb_i (mem_wstrb),
        .rdata_o (mem_rdata)
    );

endmodule

`default_nettype wire

//--- dmem_ctrl_pkg.sv
`default_nettype none

package dmem_ctrl_pkg;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RSVCHECK, // stores, LR and SC only
        ST_ACCESS
    } state_e;

endpackage

`default_nettype wire

//--- dmem_port_fsm.sv
`default_nettype none

`include "dmem_config.svh"

module dmem_port_fsm (
    input  wire                                          clk_i,
    input  wire                                          arst_n_i,
    input  wire                                          grant_valid_i,
    input  wire  dmem_req_pkg::core_t                    grant_core_i,
    input  wire  dmem_req_pkg::op_e   [`DMEM_NCORES-1:0] op_i,
    input  wire  dmem_req_pkg::addr_t [`DMEM_NCORES-1:0] addr_i,
    input  wire  dmem_req_pkg::data_t [`DMEM_NCORES-1:0] wdata_i,
    input  wire  dmem_req_pkg::strb_t [`DMEM_NCORES-1:0] wstrb_i,
    input  wire                                          sc_ok_i,
    input  wire  dmem_req_pkg::data_t                    mem_rdata_i,
    output logic                                         take_o,
    output logic [`DMEM_NCORES-1:0]                      serve_o,
    output logic                                         rsv_check_o,
    output dmem_req_pkg::core_t                          rsv_core_o,
    output dmem_req_pkg::op_e                            rsv_op_o,
    output dmem_req_pkg::addr_t                          rsv_addr_o,
    output logic                                         rsv_clear_o,
    output logic                                         mem_re_o,
    output logic                                         mem_we_o,
    output dmem_req_pkg::addr_t                          mem_addr_o,
    output dmem_req_pkg::data_t                          mem_wdata_o,
    output dmem_req_pkg::strb_t                          mem_wstrb_o,
    output dmem_req_pkg::data_t  [`DMEM_NCORES-1:0]      rdata_o
);

    dmem_ctrl_pkg::state_e  state_q;
    dmem_req_pkg::core_t    sel_core_q;
    logic                   ret_valid_q; // result goes out this cycle
    logic                   ret_is_sc_q;
    dmem_req_pkg::op_e      sel_op;
    logic                   in_access;

    assign sel_op    = op_i[sel_core_q];
    assign in_access = (state_q == dmem_ctrl_pkg::ST_ACCESS);
    assign take_o    = (state_q == dmem_ctrl_pkg::ST_IDLE) && grant_valid_i;

    assign rsv_check_o = (state_q == dmem_ctrl_pkg::ST_RSVCHECK);
    assign rsv_core_o  = sel_core_q;
    assign rsv_op_o    = sel_op;
    assign rsv_addr_o  = addr_i[sel_core_q];
    assign rsv_clear_o = ret_valid_q;

    // failed SC must leave memory untouched
    assign mem_re_o    = in_access
                       && (sel_op == dmem_req_pkg::OP_LOAD || sel_op == dmem_req_pkg::OP_LR);
    assign mem_we_o    = in_access
                       && (sel_op == dmem_req_pkg::OP_STORE
                           || (sel_op == dmem_req_pkg::OP_SC && sc_ok_i));
    assign mem_addr_o  = addr_i[sel_core_q];
    assign mem_wdata_o = wdata_i[sel_core_q];
    assign mem_wstrb_o = wstrb_i[sel_core_q];

    always_comb begin
        for (int k = 0; k < `DMEM_NCORES; k++) begin
            serve_o[k] = in_access && (sel_core_q == dmem_req_pkg::core_t'(k));
            rdata_o[k] = '0;
            if (ret_valid_q && sel_core_q == dmem_req_pkg::core_t'(k)) begin
                // SC returns 0 on success
                rdata_o[k] = ret_is_sc_q ? dmem_req_pkg::data_t'(!sc_ok_i) : mem_rdata_i;
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= dmem_ctrl_pkg::ST_IDLE;
            sel_core_q  <= '0;
            ret_valid_q <= 1'b0;
            ret_is_sc_q <= 1'b0;
        end else begin
            ret_valid_q <= 1'b0;
            case (state_q)
                dmem_ctrl_pkg::ST_IDLE: begin
                    if (take_o) begin
                        sel_core_q <= grant_core_i;
                        if (op_i[grant_core_i] == dmem_req_pkg::OP_LOAD) begin
                            state_q <= dmem_ctrl_pkg::ST_ACCESS; // no reservation work
                        end else begin
                            state_q <= dmem_ctrl_pkg::ST_RSVCHECK;
                        end
                    end
                end
                dmem_ctrl_pkg::ST_RSVCHECK: state_q <= dmem_ctrl_pkg::ST_ACCESS;
                dmem_ctrl_pkg::ST_ACCESS: begin
                    state_q     <= dmem_ctrl_pkg::ST_IDLE;
                    ret_valid_q <= 1'b1;
                    ret_is_sc_q <= (sel_op == dmem_req_pkg::OP_SC);
                end
                default: state_q <= dmem_ctrl_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- dmem_req_pkg.sv
`default_nettype none

`include "dmem_config.svh"

package dmem_req_pkg;

    typedef logic [`DMEM_ADDRW-1:0]           addr_t;
    typedef logic [`DMEM_DATAW-1:0]           data_t;
    typedef logic [`DMEM_DATAW/8-1:0]         strb_t; // one bit per byte
    typedef logic [$clog2(`DMEM_NCORES)-1:0]  core_t;

    // request kind as held in a slot
    typedef enum logic [1:0] {
        OP_LOAD,
        OP_STORE,
        OP_LR,
        OP_SC
    } op_e;

endpackage

`default_nettype wire

//--- dmem_req_slots.sv
`default_nettype none

`include "dmem_config.svh"

module dmem_req_slots (
    input  wire                                         clk_i,
    input  wire                                         arst_n_i,
    input  wire  [`DMEM_NCORES-1:0]                     re_i,
    input  wire  [`DMEM_NCORES-1:0]                     we_i,
    input  wire  dmem_req_pkg::addr_t [`DMEM_NCORES-1:0] addr_i,
    input  wire  dmem_req_pkg::data_t [`DMEM_NCORES-1:0] wdata_i,
    input  wire  dmem_req_pkg::strb_t [`DMEM_NCORES-1:0] wstrb_i,
    input  wire  [`DMEM_NCORES-1:0]                     is_lr_i,
    input  wire  [`DMEM_NCORES-1:0]                     is_sc_i,
    input  wire  [`DMEM_NCORES-1:0]                     serve_i,
    output logic [`DMEM_NCORES-1:0]                     pending_o,
    output dmem_req_pkg::op_e   [`DMEM_NCORES-1:0]      op_o,
    output dmem_req_pkg::addr_t [`DMEM_NCORES-1:0]      addr_o,
    output dmem_req_pkg::data_t [`DMEM_NCORES-1:0]      wdata_o,
    output dmem_req_pkg::strb_t [`DMEM_NCORES-1:0]      wstrb_o,
    output logic [`DMEM_NCORES-1:0]                     stall_o
);

    logic [`DMEM_NCORES-1:0]                valid_q;
    logic [`DMEM_NCORES-1:0]                stall_q;
    logic [`DMEM_NCORES-1:0]                capture;
    dmem_req_pkg::op_e [`DMEM_NCORES-1:0]   op_new;

    always_comb begin
        for (int k = 0; k < `DMEM_NCORES; k++) begin
            capture[k] = !valid_q[k] && (re_i[k] || we_i[k]); // full slot ignores inputs
            if (re_i[k]) begin
                op_new[k] = is_lr_i[k] ? dmem_req_pkg::OP_LR : dmem_req_pkg::OP_LOAD;
            end else begin
                op_new[k] = is_sc_i[k] ? dmem_req_pkg::OP_SC : dmem_req_pkg::OP_STORE;
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
            stall_q <= '0;
        end else begin
            for (int k = 0; k < `DMEM_NCORES; k++) begin
                stall_q[k] <= (re_i[k] || we_i[k] || valid_q[k]) && !serve_i[k];
                if (capture[k]) begin
                    valid_q[k] <= 1'b1;
                end else if (serve_i[k]) begin
                    valid_q[k] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int k = 0; k < `DMEM_NCORES; k++) begin
            if (capture[k]) begin
                op_o[k]    <= op_new[k];
                addr_o[k]  <= addr_i[k];
                wdata_o[k] <= wdata_i[k];
                wstrb_o[k] <= wstrb_i[k];
            end
        end
    end

    assign pending_o = valid_q;
    assign stall_o   = stall_q;

endmodule

`default_nettype wire

//--- dmem_reservation_table.sv
`default_nettype none

`include "dmem_config.svh"

module dmem_reservation_table (
    input  wire                         clk_i,
    input  wire                         arst_n_i,
    input  wire                         check_i,
    input  wire  dmem_req_pkg::core_t   core_i,
    input  wire  dmem_req_pkg::op_e     op_i,
    input  wire  dmem_req_pkg::addr_t   addr_i,
    input  wire                         clear_i,
    output logic                        sc_ok_o
);

    logic [`DMEM_NCORES-1:0]                    rsv_valid_q;
    dmem_req_pkg::addr_t [`DMEM_NCORES-1:0]     rsv_addr_q;
    logic                                       sc_ok_q;
    logic [`DMEM_NCORES-1:0]                    addr_hit; // reservations on addr_i
    logic                                       own_hit;

    always_comb begin
        for (int k = 0; k < `DMEM_NCORES; k++) begin
            addr_hit[k] = rsv_valid_q[k] && (rsv_addr_q[k] == addr_i);
        end
        own_hit = addr_hit[core_i];
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsv_valid_q <= '0;
            sc_ok_q     <= 1'b0;
        end else if (check_i) begin
            case (op_i)
                dmem_req_pkg::OP_LR:    rsv_valid_q[core_i] <= 1'b1;
                dmem_req_pkg::OP_SC: begin
                    sc_ok_q <= own_hit;
                    if (own_hit) begin
                        rsv_valid_q <= rsv_valid_q & ~addr_hit;
                    end
                end
                dmem_req_pkg::OP_STORE: rsv_valid_q <= rsv_valid_q & ~addr_hit;
                default: ;
            endcase
        end else if (clear_i) begin
            sc_ok_q <= 1'b0; // verdict already returned
        end
    end

    always_ff @(posedge clk_i) begin
        if (check_i && op_i == dmem_req_pkg::OP_LR) begin
            rsv_addr_q[core_i] <= addr_i;
        end
    end

    assign sc_ok_o = sc_ok_q;

endmodule

`default_nettype wire

//--- dmem_rr_arbiter.sv
`default_nettype none

`include "dmem_config.svh"

module dmem_rr_arbiter (
    input  wire                         clk_i,
    input  wire                         arst_n_i,
    input  wire  [`DMEM_NCORES-1:0]     pending_i,
    input  wire                         take_i,
    output logic                        grant_valid_o,
    output dmem_req_pkg::core_t         grant_core_o
);

    dmem_req_pkg::core_t ptr_q; // first slot looked at

    // first pending slot at or after the pointer
    always_comb begin
        int unsigned idx;
        grant_valid_o = 1'b0;
        grant_core_o  = '0;
        for (int i = 0; i < `DMEM_NCORES; i++) begin
            idx = (int'(ptr_q) + i) % `DMEM_NCORES;
            if (!grant_valid_o && pending_i[idx]) begin
                grant_valid_o = 1'b1;
                grant_core_o  = dmem_req_pkg::core_t'(idx);
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ptr_q <= '0;
        end else if (take_i) begin
            if (int'(grant_core_o) == `DMEM_NCORES - 1) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= grant_core_o + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- dmem_sram.sv
`default_nettype none

`include "dmem_config.svh"

module dmem_sram (
    input  wire                         clk_i,
    input  wire                         re_i,
    input  wire                         we_i,
    input  wire  dmem_req_pkg::addr_t   addr_i,
    input  wire  dmem_req_pkg::data_t   wdata_i,
    input  wire  dmem_req_pkg::strb_t   wstrb_i,
    output dmem_req_pkg::data_t         rdata_o
);

    dmem_req_pkg::data_t mem_q [2**`DMEM_ADDRW];
    dmem_req_pkg::data_t rdata_q;

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int b = 0; b < `DMEM_DATAW/8; b++) begin
                if (wstrb_i[b]) begin
                    mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
        if (re_i) begin
            rdata_q <= mem_q[addr_i]; // held until next read
        end
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
verilator --binary --assert --top-module tb_dmem_controller \
    -f dmem_controller.f -o sim_dmem_controller \
    && ./obj_dir/sim_dmem_controller > sim.log 2>&1 \
    ; cat sim.log \
    && grep -q "Simulation passed" sim.log \
    && echo "run ok" \
    || { echo "run not ok, see sim.log"; exit 1; }

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk_o
);

    localparam int half_period = 5; // period 10

    initial begin
        clk_o = 1'b0;
        forever #half_period clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

//--- tb_dmem_controller.sv
`default_nettype none

`include "dmem_config.svh"

module tb_dmem_controller;

    localparam int n_random        = 400;
    localparam int watchdog_cycles = n_random * 20 * `DMEM_NCORES;
    // small pool so reservations collide
    localparam dmem_req_pkg::addr_t pool_addr [4] = '{6'h05, 6'h12, 6'h2a, 6'h3f};

    logic                                   clk_i;
    logic                                   arst_n_i;
    logic [`DMEM_NCORES-1:0]                re_i;
    logic [`DMEM_NCORES-1:0]                we_i;
    dmem_req_pkg::addr_t [`DMEM_NCORES-1:0] addr_i;
    dmem_req_pkg::data_t [`DMEM_NCORES-1:0] wdata_i;
    dmem_req_pkg::strb_t [`DMEM_NCORES-1:0] wstrb_i;
    logic [`DMEM_NCORES-1:0]                is_lr_i;
    logic [`DMEM_NCORES-1:0]                is_sc_i;
    dmem_req_pkg::data_t [`DMEM_NCORES-1:0] rdata_o;
    logic [`DMEM_NCORES-1:0]                stall_o;

    // reference model
    dmem_req_pkg::data_t        model_mem [2**`DMEM_ADDRW];
    logic [`DMEM_NCORES-1:0]    rsv_valid = '0;
    dmem_req_pkg::addr_t        rsv_addr [`DMEM_NCORES];

    logic [`DMEM_NCORES-1:0]    busy = '0; // one outstanding request per core
    dmem_req_pkg::op_e          req_op [`DMEM_NCORES];
    dmem_req_pkg::addr_t        req_addr [`DMEM_NCORES];
    dmem_req_pkg::data_t        req_data [`DMEM_NCORES];
    dmem_req_pkg::strb_t        req_strb [`DMEM_NCORES];
    dmem_req_pkg::data_t        last_rdata [`DMEM_NCORES];
    logic [`DMEM_NCORES-1:0]    stall_prev = '0;

    integer seed = 32'ha827_cb73;
    int     errors = 0;
    int     checks = 0;
    int     tests = 0;
    int     failed_tests = 0;

    tb_clock_gen u_clk (
        .clk_o (clk_i)
    );

    dmem_controller dut_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .re_i     (re_i),
        .we_i     (we_i),
        .addr_i   (addr_i),
        .wdata_i  (wdata_i),
        .wstrb_i  (wstrb_i),
        .is_lr_i  (is_lr_i),
        .is_sc_i  (is_sc_i),
        .rdata_o  (rdata_o),
        .stall_o  (stall_o)
    );

    function automatic dmem_req_pkg::data_t merge_bytes(input dmem_req_pkg::data_t old,
                                                         input dmem_req_pkg::data_t wdata,
                                                         input dmem_req_pkg::strb_t strb);
        dmem_req_pkg::data_t res;
        res = old;
        for (int b = 0; b < `DMEM_DATAW/8; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic compare_load_data(input int core, input dmem_req_pkg::data_t got,
                                     input dmem_req_pkg::data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH rdata_o[%0d] load: got %h, expected %h", core, got, exp);
        end
    endtask

    task automatic compare_sc_flag(input int core, input dmem_req_pkg::data_t got,
                                   input dmem_req_pkg::data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH rdata_o[%0d] sc flag: got %h, expected %h", core, got, exp);
        end
    endtask

    task automatic clear_reservations(input dmem_req_pkg::addr_t a);
        for (int j = 0; j < `DMEM_NCORES; j++) begin
            if (rsv_valid[j] && rsv_addr[j] == a) begin
                rsv_valid[j] = 1'b0;
            end
        end
    endtask

    // model step, in service order
    task automatic complete_request(input int k);
        dmem_req_pkg::data_t got;
        dmem_req_pkg::addr_t a;
        logic                sc_ok;
        got = rdata_o[k];
        a   = req_addr[k];
        last_rdata[k] = got;
        case (req_op[k])
            dmem_req_pkg::OP_LOAD: compare_load_data(k, got, model_mem[a]);
            dmem_req_pkg::OP_LR: begin
                compare_load_data(k, got, model_mem[a]);
                rsv_valid[k] = 1'b1;
                rsv_addr[k]  = a;
            end
            dmem_req_pkg::OP_STORE: begin
                model_mem[a] = merge_bytes(model_mem[a], req_data[k], req_strb[k]);
                clear_reservations(a);
            end
            default: begin
                sc_ok = rsv_valid[k] && (rsv_addr[k] == a);
                compare_sc_flag(k, got, sc_ok ? 32'd0 : 32'd1);
                if (sc_ok) begin
                    model_mem[a] = merge_bytes(model_mem[a], req_data[k], req_strb[k]);
                    clear_reservations(a);
                end
            end
        endcase
        busy[k] = 1'b0;
    endtask

    always @(negedge clk_i) begin : monitor
        if (arst_n_i) begin
            for (int k = 0; k < `DMEM_NCORES; k++) begin
                if (stall_prev[k] && !stall_o[k]) begin
                    if (busy[k]) begin
                        complete_request(k);
                    end else begin
                        errors++;
                        $display("core %0d completed a request it never issued", k);
                    end
                end else if (rdata_o[k] !== '0) begin
                    errors++;
                    $display("MISMATCH rdata_o[%0d] idle: got %h, expected %h", k, rdata_o[k],
                             32'h0);
                end
            end
        end
        stall_prev = stall_o;
    end

    task automatic next_cycle();
        @(posedge clk_i);
        re_i <= '0; // strobes last one cycle
        we_i <= '0;
    endtask

    task automatic issue_request(input int k, input dmem_req_pkg::op_e op,
                                 input dmem_req_pkg::addr_t a, input dmem_req_pkg::data_t d,
                                 input dmem_req_pkg::strb_t s);
        re_i[k]    <= (op == dmem_req_pkg::OP_LOAD) || (op == dmem_req_pkg::OP_LR);
        we_i[k]    <= (op == dmem_req_pkg::OP_STORE) || (op == dmem_req_pkg::OP_SC);
        is_lr_i[k] <= (op == dmem_req_pkg::OP_LR);
        is_sc_i[k] <= (op == dmem_req_pkg::OP_SC);
        addr_i[k]  <= a;
        wdata_i[k] <= d;
        wstrb_i[k] <= s;
        req_op[k]   = op;
        req_addr[k] = a;
        req_data[k] = d;
        req_strb[k] = s;
        busy[k]     = 1'b1;
    endtask

    task automatic run_op(input int k, input dmem_req_pkg::op_e op, input dmem_req_pkg::addr_t a,
                          input dmem_req_pkg::data_t d, input dmem_req_pkg::strb_t s,
                          output dmem_req_pkg::data_t got);
        next_cycle();
        while (busy[k]) begin
            next_cycle();
        end
        issue_request(k, op, a, d, s);
        do begin
            next_cycle();
        end while (busy[k]);
        got = last_rdata[k];
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %-10s ok", name);
        end else begin
            failed_tests++;
            $display("test %-10s FAILED, %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk_i);
        $display("timeout after %0d cycles, busy cores %b", watchdog_cycles, busy);
        $display("Simulation failed");
        $finish;
    end

    initial begin : stimulus
        int                  e0;
        int                  rand_left;
        logic [31:0]         r;
        dmem_req_pkg::data_t got;
        arst_n_i = 1'b0;
        re_i     = '0;
        we_i     = '0;
        addr_i   = '0;
        wdata_i  = '0;
        wstrb_i  = '0;
        is_lr_i  = '0;
        is_sc_i  = '0;
        repeat (16) @(posedge clk_i);
        arst_n_i <= 1'b1;

        e0 = errors; // known contents before any load
        for (int k = 0; k < 4; k++) begin
            run_op(k % `DMEM_NCORES, dmem_req_pkg::OP_STORE, pool_addr[k],
                   32'h0123_4567 + k * 32'h1111_1111, 4'hf, got);
        end
        report_test("init", e0);

        e0 = errors;
        run_op(1, dmem_req_pkg::OP_STORE, pool_addr[0], 32'haabb_ccdd, 4'b0101, got);
        run_op(2, dmem_req_pkg::OP_LOAD, pool_addr[0], '0, '0, got);
        compare_load_data(2, got, 32'h01bb_45dd);
        report_test("merge", e0);

        e0 = errors;
        run_op(0, dmem_req_pkg::OP_LR, pool_addr[1], '0, '0, got);
        run_op(0, dmem_req_pkg::OP_SC, pool_addr[1], 32'hcafe_f00d, 4'hf, got);
        compare_sc_flag(0, got, 32'd0);
        run_op(3, dmem_req_pkg::OP_LOAD, pool_addr[1], '0, '0, got);
        compare_load_data(3, got, 32'hcafe_f00d);
        report_test("lr_sc", e0);

        e0 = errors;
        run_op(2, dmem_req_pkg::OP_SC, pool_addr[2], 32'hdead_beef, 4'hf, got);
        compare_sc_flag(2, got, 32'd1); // no reservation
        run_op(2, dmem_req_pkg::OP_LR, pool_addr[3], '0, '0, got);
        run_op(2, dmem_req_pkg::OP_SC, pool_addr[2], 32'hdead_beef, 4'hf, got);
        compare_sc_flag(2, got, 32'd1); // other address
        run_op(1, dmem_req_pkg::OP_LOAD, pool_addr[2], '0, '0, got);
        compare_load_data(1, got, 32'h2345_6789);
        report_test("sc_fail", e0);

        e0 = errors;
        run_op(1, dmem_req_pkg::OP_LR, pool_addr[3], '0, '0, got);
        run_op(3, dmem_req_pkg::OP_STORE, pool_addr[3], 32'h5555_aaaa, 4'b0011, got);
        run_op(1, dmem_req_pkg::OP_SC, pool_addr[3], 32'h1234_5678, 4'hf, got);
        compare_sc_flag(1, got, 32'd1);
        run_op(0, dmem_req_pkg::OP_LR, pool_addr[0], '0, '0, got);
        run_op(2, dmem_req_pkg::OP_LR, pool_addr[0], '0, '0, got);
        run_op(2, dmem_req_pkg::OP_SC, pool_addr[0], 32'h0bad_cafe, 4'hf, got);
        compare_sc_flag(2, got, 32'd0);
        run_op(0, dmem_req_pkg::OP_SC, pool_addr[0], 32'h7777_7777, 4'hf, got);
        compare_sc_flag(0, got, 32'd1);
        report_test("steal", e0);

        e0 = errors;
        rand_left = n_random;
        while (rand_left > 0 || busy != '0) begin
            next_cycle();
            for (int k = 0; k < `DMEM_NCORES; k++) begin
                r = $random(seed);
                if (!busy[k] && rand_left > 0 && r[1:0] == 2'b00) begin
                    issue_request(k, dmem_req_pkg::op_e'(r[3:2]), pool_addr[r[5:4]],
                                  $random(seed), r[11:8]);
                    rand_left--;
                end
            end
        end
        report_test("random", e0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed_tests, checks,
                 errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
